//--- hw/bip_pkg.sv
`default_nettype none

package bip_pkg;

   localparam int NB_BITS       = 16;     // data and instruction word
   localparam int NB_OPCODE     = 5;      // top field of the instruction
   localparam int NB_OPERAND    = 11;     // address or immediate

   localparam int INS_MEM_DEPTH = 2048;
   localparam int DTA_MEM_DEPTH = 2048;
   localparam int NB_INS_ADDR   = 11;     // program counter width
   localparam int NB_DTA_ADDR   = 11;

   // program image, shared with the testbench model
   localparam string PROG_FILE  = "test/prog.hex";

   typedef enum logic [NB_OPCODE-1:0] {
      HLT  = 5'd0,                        // stop the machine
      STO  = 5'd1,                        // mem[op] = acc
      LD   = 5'd2,                        // acc = mem[op]
      LDI  = 5'd3,                        // acc = sext(op)
      ADD  = 5'd4,                        // acc = acc + mem[op]
      ADDI = 5'd5,                        // acc = acc + sext(op)
      SUB  = 5'd6,                        // acc = acc - mem[op]
      SUBI = 5'd7                         // acc = acc - sext(op)
   } opcode_e;

   typedef enum logic [1:0] {
      SEL_A_MEM = 2'd0,                   // memory read data
      SEL_A_IMM = 2'd1,                   // sign-extended immediate
      SEL_A_ALU = 2'd2                    // adder result
   } sel_a_e;

   typedef enum logic {
      SEL_B_MEM = 1'b0,
      SEL_B_IMM = 1'b1
   } sel_b_e;

   typedef enum logic {
      ALU_ADD = 1'b0,
      ALU_SUB = 1'b1
   } alu_op_e;

endpackage

`default_nettype wire

//--- hw/bip_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decoded controls from the control unit into the datapath
interface bip_ctrl_if import bip_pkg::*; ();

   logic [NB_OPERAND-1:0] operand;        // raw operand field
   sel_a_e                sel_a;
   sel_b_e                sel_b;
   logic                  wr_acc;         // accumulator load enable
   alu_op_e               alu_op;

   modport control (
      output operand, sel_a, sel_b, wr_acc, alu_op
   );

   modport datapath (
      input  operand, sel_a, sel_b, wr_acc, alu_op
   );

endinterface

// data memory bus, single cycle with no handshake
interface bip_mem_if import bip_pkg::*; ();

   logic [NB_DTA_ADDR-1:0] addr;
   logic [NB_BITS-1:0]     wdata;         // store data from acc
   logic [NB_BITS-1:0]     rdata;         // valid in the address cycle
   logic                   wr;
   logic                   rd;

   modport master (
      output addr, wdata, wr, rd,
      input  rdata
   );

   modport memory (
      input  addr, wdata, wr, rd,
      output rdata
   );

endinterface

`default_nettype wire

//--- hw/bip_control.sv
`timescale 1ns/1ps
`default_nettype none

module bip_control import bip_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_arst_n,
   input  wire [NB_BITS-1:0]       i_instruction,
   output logic [NB_INS_ADDR-1:0]  o_addr_ins,
   output logic                    o_halt,
   bip_ctrl_if.control             ctrl,
   output logic [NB_DTA_ADDR-1:0]  o_mem_addr,
   output logic                    o_mem_wr,
   output logic                    o_mem_rd
);

   logic [NB_INS_ADDR-1:0] pc;
   logic                   halted;
   opcode_e                opcode;
   logic [NB_OPERAND-1:0]  operand;
   logic                   hlt_dec;       // current word stops the machine

   assign opcode  = opcode_e'(i_instruction[NB_BITS-1 -: NB_OPCODE]);
   assign operand = i_instruction[NB_OPERAND-1:0];

   // pc sits on the HLT word once it is reached
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (!halted) begin
         if (hlt_dec) begin
            halted <= 1'b1;
         end else begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_comb begin
      hlt_dec     = 1'b0;
      ctrl.sel_a  = SEL_A_ALU;
      ctrl.sel_b  = SEL_B_MEM;
      ctrl.wr_acc = 1'b0;
      ctrl.alu_op = ALU_ADD;
      o_mem_wr    = 1'b0;
      o_mem_rd    = 1'b0;
      if (!halted) begin                  // halted decode is a nop
         case (opcode)
            STO: begin
               o_mem_wr = 1'b1;
            end
            LD: begin
               o_mem_rd    = 1'b1;
               ctrl.sel_a  = SEL_A_MEM;
               ctrl.wr_acc = 1'b1;
            end
            LDI: begin
               ctrl.sel_a  = SEL_A_IMM;
               ctrl.wr_acc = 1'b1;
            end
            ADD, SUB: begin
               o_mem_rd    = 1'b1;
               ctrl.sel_b  = SEL_B_MEM;
               ctrl.wr_acc = 1'b1;
               ctrl.alu_op = (opcode == SUB) ? ALU_SUB : ALU_ADD;
            end
            ADDI, SUBI: begin
               ctrl.sel_b  = SEL_B_IMM;
               ctrl.wr_acc = 1'b1;
               ctrl.alu_op = (opcode == SUBI) ? ALU_SUB : ALU_ADD;
            end
            default: begin
               hlt_dec = 1'b1;            // HLT and unused codes
            end
         endcase
      end
   end

   assign ctrl.operand = operand;
   assign o_mem_addr   = operand;         // direct addressing only
   assign o_addr_ins   = pc;
   assign o_halt       = halted;

endmodule

`default_nettype wire

//--- hw/bip_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module bip_datapath import bip_pkg::*; (
   input  wire                 i_clk,
   input  wire                 i_arst_n,
   bip_ctrl_if.datapath        ctrl,
   input  wire [NB_BITS-1:0]   i_mem_rdata,
   output logic [NB_BITS-1:0]  o_acc
);

   logic [NB_BITS-1:0] acc;
   logic [NB_BITS-1:0] imm_ext;           // operand widened to a word
   logic [NB_BITS-1:0] op_b;
   logic [NB_BITS-1:0] alu_res;
   logic [NB_BITS-1:0] acc_next;

   assign imm_ext = {{(NB_BITS-NB_OPERAND){ctrl.operand[NB_OPERAND-1]}}, ctrl.operand};

   assign op_b = (ctrl.sel_b == SEL_B_IMM) ? imm_ext : i_mem_rdata;

   // wraps at the word width
   assign alu_res = (ctrl.alu_op == ALU_SUB) ? acc - op_b : acc + op_b;

   always_comb begin
      case (ctrl.sel_a)
         SEL_A_MEM: acc_next = i_mem_rdata;
         SEL_A_IMM: acc_next = imm_ext;
         default:   acc_next = alu_res;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         acc <= '0;
      end else if (ctrl.wr_acc) begin
         acc <= acc_next;
      end
   end

   assign o_acc = acc;                    // also the store data

endmodule

`default_nettype wire

//--- hw/bip_prog_mem.sv
`timescale 1ns/1ps
`default_nettype none

module bip_prog_mem import bip_pkg::*; (
   input  wire [NB_INS_ADDR-1:0]  i_addr,
   output logic [NB_BITS-1:0]     o_instruction
);

   logic [NB_BITS-1:0] rom [INS_MEM_DEPTH];

   // unwritten words stay zero and decode as HLT
   initial begin
      for (int i = 0; i < INS_MEM_DEPTH; i++) begin
         rom[i] = '0;
      end
      $readmemh(PROG_FILE, rom);
   end

   assign o_instruction = rom[i_addr];    // async read

endmodule

`default_nettype wire

//--- hw/bip_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module bip_data_mem import bip_pkg::*; (
   input  wire           i_clk,
   bip_mem_if.memory     mem
);

   logic [NB_BITS-1:0] ram [DTA_MEM_DEPTH];

   initial begin
      for (int i = 0; i < DTA_MEM_DEPTH; i++) begin
         ram[i] = '0;                     // power-up contents
      end
   end

   always_ff @(posedge i_clk) begin
      if (mem.wr) begin
         ram[mem.addr] <= mem.wdata;
      end
   end

   // read data only while a read is requested
   assign mem.rdata = mem.rd ? ram[mem.addr] : '0;

endmodule

`default_nettype wire

//--- hw/bip_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module bip_cpu import bip_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_arst_n,
   output logic [NB_INS_ADDR-1:0]  o_addr_ins,
   input  wire [NB_BITS-1:0]       i_instruction,
   bip_mem_if.master               mem,
   output logic [NB_BITS-1:0]      o_acc,
   output logic                    o_halt
);

   bip_ctrl_if ctrl_if ();

   logic [NB_BITS-1:0] acc;

   bip_control u_control (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_instruction (i_instruction),
      .o_addr_ins    (o_addr_ins),
      .o_halt        (o_halt),
      .ctrl          (ctrl_if.control),
      .o_mem_addr    (mem.addr),
      .o_mem_wr      (mem.wr),
      .o_mem_rd      (mem.rd)
   );

   bip_datapath u_datapath (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .ctrl        (ctrl_if.datapath),
      .i_mem_rdata (mem.rdata),
      .o_acc       (acc)
   );

   assign mem.wdata = acc;                // STO writes the accumulator
   assign o_acc     = acc;

endmodule

`default_nettype wire

//--- hw/bip_top.sv
`timescale 1ns/1ps
`default_nettype none

module bip_top import bip_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_arst_n,
   output logic [NB_BITS-1:0]      o_acc,
   output logic [NB_INS_ADDR-1:0]  o_pc,
   output logic                    o_halt,
   output logic                    o_mem_wr,
   output logic [NB_DTA_ADDR-1:0]  o_mem_addr,
   output logic [NB_BITS-1:0]      o_mem_wdata
);

   bip_mem_if mem_if ();

   logic [NB_INS_ADDR-1:0] addr_ins;
   logic [NB_BITS-1:0]     instruction;

   bip_cpu u_cpu (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .o_addr_ins    (addr_ins),
      .i_instruction (instruction),
      .mem           (mem_if.master),
      .o_acc         (o_acc),
      .o_halt        (o_halt)
   );

   bip_prog_mem u_prog_mem (
      .i_addr        (addr_ins),
      .o_instruction (instruction)
   );

   bip_data_mem u_data_mem (
      .i_clk (i_clk),
      .mem   (mem_if.memory)
   );

   // observation taps on the data bus
   assign o_pc        = addr_ins;
   assign o_mem_wr    = mem_if.wr;
   assign o_mem_addr  = mem_if.addr;
   assign o_mem_wdata = mem_if.wdata;

endmodule

`default_nettype wire

//--- test/bip_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bip_clk_gen (
   output logic o_clk,
   output logic o_arst_n
);

   localparam real CLK_PERIOD  = 8.0;     // ns
   localparam int  RST_CYCLES  = 5;
   localparam real DRIVE_DELAY = 1.0;     // ns past the rising edge

   initial begin
      o_clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2.0);
         o_clk = ~o_clk;
      end
   end

   initial begin
      o_arst_n = 1'b1;
      #(DRIVE_DELAY);
      o_arst_n = 1'b0;                    // clean falling edge into reset
      repeat (RST_CYCLES) @(posedge o_clk);
      #(DRIVE_DELAY);
      o_arst_n = 1'b1;                    // release off the edge
   end

endmodule

`default_nettype wire

//--- test/bip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bip_tb import bip_pkg::*; ();

   localparam int PROG_WORDS  = 24;               // words in prog.hex
   localparam int MAX_CYCLES  = PROG_WORDS + 40;  // program plus margin
   localparam int HOLD_CYCLES = 8;                // watched after halt

   logic                   clk;
   logic                   arst_n;
   logic [NB_BITS-1:0]     acc;
   logic [NB_INS_ADDR-1:0] pc;
   logic                   halt;
   logic                   mem_wr;
   logic [NB_DTA_ADDR-1:0] mem_addr;
   logic [NB_BITS-1:0]     mem_wdata;

   // golden model of the instruction set
   logic [NB_BITS-1:0]     m_prog [INS_MEM_DEPTH];
   logic [NB_BITS-1:0]     m_mem  [DTA_MEM_DEPTH];
   logic [NB_INS_ADDR-1:0] m_pc;
   logic [NB_BITS-1:0]     m_acc;
   logic                   m_halt;
   logic [NB_BITS-1:0]     m_word;
   logic [NB_OPCODE-1:0]   m_opcode;
   logic [NB_OPERAND-1:0]  m_operand;
   logic                   m_sto;         // store due this cycle

   // outputs seen once the machine halted
   logic                   frozen_valid;
   logic [NB_INS_ADDR-1:0] frozen_pc;
   logic [NB_BITS-1:0]     frozen_acc;

   int errors    = 0;
   int cycles    = 0;
   int timeouts  = 0;

   bip_clk_gen clk_gen_inst (
      .o_clk    (clk),
      .o_arst_n (arst_n)
   );

   bip_top bip_top_inst (
      .i_clk       (clk),
      .i_arst_n    (arst_n),
      .o_acc       (acc),
      .o_pc        (pc),
      .o_halt      (halt),
      .o_mem_wr    (mem_wr),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata)
   );

   function automatic logic [NB_BITS-1:0] sign_extend(input logic [NB_OPERAND-1:0] value);
      return {{(NB_BITS - NB_OPERAND){value[NB_OPERAND-1]}}, value};
   endfunction

   task automatic report_mismatch(input string name, input logic [NB_BITS-1:0] expected,
                                  input logic [NB_BITS-1:0] actual);
      errors++;
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
   endtask

   initial begin
      for (int i = 0; i < INS_MEM_DEPTH; i++) begin
         m_prog[i] = '0;                  // past the file reads as HLT
      end
      for (int i = 0; i < DTA_MEM_DEPTH; i++) begin
         m_mem[i] = '0;
      end
      $readmemh(PROG_FILE, m_prog);
   end

   assign m_word    = m_prog[m_pc];
   assign m_opcode  = m_word[NB_BITS-1 -: NB_OPCODE];
   assign m_operand = m_word[NB_OPERAND-1:0];
   assign m_sto     = !m_halt && (m_opcode == STO);

   // one instruction per clock
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_pc   <= '0;
         m_acc  <= '0;
         m_halt <= 1'b0;
      end else if (!m_halt) begin
         m_pc <= m_pc + 1'b1;
         case (m_opcode)
            STO:  m_mem[m_operand] <= m_acc;
            LD:   m_acc <= m_mem[m_operand];
            LDI:  m_acc <= sign_extend(m_operand);
            ADD:  m_acc <= m_acc + m_mem[m_operand];
            ADDI: m_acc <= m_acc + sign_extend(m_operand);
            SUB:  m_acc <= m_acc - m_mem[m_operand];
            SUBI: m_acc <= m_acc - sign_extend(m_operand);
            default: begin
               m_halt <= 1'b1;            // HLT and unused codes
               m_pc   <= m_pc;            // pc parks on the stop word
            end
         endcase
      end
   end

   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frozen_valid <= 1'b0;
         frozen_pc    <= '0;
         frozen_acc   <= '0;
      end else if (halt && !frozen_valid) begin
         frozen_valid <= 1'b1;
         frozen_pc    <= pc;
         frozen_acc   <= acc;
      end
   end

   // values held by reset
   a_rst_pc: assert property (@(posedge clk) !arst_n |-> pc == '0)
      else report_mismatch("o_pc", '0, $sampled(pc));
   a_rst_acc: assert property (@(posedge clk) !arst_n |-> acc == '0)
      else report_mismatch("o_acc", '0, $sampled(acc));
   a_rst_halt: assert property (@(posedge clk) !arst_n |-> !halt)
      else report_mismatch("o_halt", '0, $sampled(halt));
   a_rst_wr: assert property (@(posedge clk) !arst_n |-> !mem_wr)
      else report_mismatch("o_mem_wr", '0, $sampled(mem_wr));

   // architectural state against the model
   a_pc: assert property (@(posedge clk) disable iff (!arst_n) pc == m_pc)
      else report_mismatch("o_pc", $sampled(m_pc), $sampled(pc));
   a_acc: assert property (@(posedge clk) disable iff (!arst_n) acc == m_acc)
      else report_mismatch("o_acc", $sampled(m_acc), $sampled(acc));
   a_halt: assert property (@(posedge clk) disable iff (!arst_n) halt == m_halt)
      else report_mismatch("o_halt", $sampled(m_halt), $sampled(halt));

   // data bus during a store
   a_wr: assert property (@(posedge clk) disable iff (!arst_n) mem_wr == m_sto)
      else report_mismatch("o_mem_wr", $sampled(m_sto), $sampled(mem_wr));
   a_addr: assert property (@(posedge clk) disable iff (!arst_n) m_sto |-> mem_addr == m_operand)
      else report_mismatch("o_mem_addr", $sampled(m_operand), $sampled(mem_addr));
   a_wdata: assert property (@(posedge clk) disable iff (!arst_n) m_sto |-> mem_wdata == m_acc)
      else report_mismatch("o_mem_wdata", $sampled(m_acc), $sampled(mem_wdata));

   // nothing moves after the halt
   a_hold_pc: assert property (@(posedge clk) disable iff (!arst_n)
                               frozen_valid |-> pc == frozen_pc)
      else report_mismatch("o_pc", $sampled(frozen_pc), $sampled(pc));
   a_hold_acc: assert property (@(posedge clk) disable iff (!arst_n)
                                frozen_valid |-> acc == frozen_acc)
      else report_mismatch("o_acc", $sampled(frozen_acc), $sampled(acc));
   a_hold_wr: assert property (@(posedge clk) disable iff (!arst_n) frozen_valid |-> !mem_wr)
      else report_mismatch("o_mem_wr", '0, $sampled(mem_wr));

   initial begin
      wait (arst_n === 1'b0);
      wait (arst_n === 1'b1);
      while (halt !== 1'b1 && cycles < MAX_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (halt !== 1'b1) begin
         timeouts++;
         $display("timeout: the machine did not halt within %0d cycles after reset", MAX_CYCLES);
      end else begin
         repeat (HOLD_CYCLES) @(negedge clk);
      end
      $display("errors: %0d, timeouts: %0d, cycles to halt: %0d", errors, timeouts, cycles);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/prog.hex
// one 16-bit instruction word per line
// opcode in bits 15:11, operand in bits 10:0
1923 // ldi 0x123
0810 // sto [0x010]
1FFB // ldi -5
0811 // sto [0x011]
2BFF // addi 0x3ff, carries past 16 bits
2010 // add [0x010]
3011 // sub [0x011]
3C00 // subi -1024
0FFF // sto [0x7ff]
1C00 // ldi -1024
2C00 // addi -1024, wraps
37FF // sub [0x7ff]
1010 // ld [0x010]
1011 // ld [0x011]
17FF // ld [0x7ff]
27FF // add [0x7ff]
27FF // add [0x7ff]
3801 // subi 1
0810 // sto [0x010] over the old value
1800 // ldi 0
1010 // ld [0x010]
2020 // add [0x020] never written
3BFF // subi 0x3ff
0000 // hlt

//--- project.f
hw/bip_pkg.sv
hw/bip_ifs.sv
hw/bip_control.sv
hw/bip_datapath.sv
hw/bip_prog_mem.sv
hw/bip_data_mem.sv
hw/bip_cpu.sv
hw/bip_top.sv
test/bip_clk_gen.sv
test/bip_tb.sv

//--- Bender.yml
package:
  name: bip

sources:
  - files:
      - hw/bip_pkg.sv
      - hw/bip_ifs.sv
      - hw/bip_control.sv
      - hw/bip_datapath.sv
      - hw/bip_prog_mem.sv
      - hw/bip_data_mem.sv
      - hw/bip_cpu.sv
      - hw/bip_top.sv
  - target: test
    files:
      - test/bip_clk_gen.sv
      - test/bip_tb.sv
